// ==== unaligned_lsu.f ====
lsu_pkg.sv
mem_if.sv
store_splitter.sv
load_merger.sv
access_sequencer.sv
word_mem.sv
unaligned_lsu.sv
tb_unaligned_lsu.sv

// ==== Bender.yml ====
package:
  name: unaligned_lsu

sources:
  - lsu_pkg.sv
  - mem_if.sv
  - store_splitter.sv
  - load_merger.sv
  - access_sequencer.sv
  - word_mem.sv
  - unaligned_lsu.sv
  - target: test
    files:
      - tb_unaligned_lsu.sv

// ==== tb_unaligned_lsu.sv ====
/*
 * directed testbench for the load/store unit
 * byte-array reference model covers the whole memory
 * loads only touch bytes stored earlier, the memory is not reset
 */
`timescale 1ns/1ns

module tb_unaligned_lsu import lsu_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int MEM_BYTES    = MEM_WORDS * 4;
    localparam int WIN_BASE     = 'h100;   // window for random traffic
    localparam int WIN_WORDS    = 16;
    localparam int N_RANDOM     = 150;
    localparam int N_OPS        = 2 + 16 + 27 + WIN_WORDS + N_RANDOM + 4;
    localparam int CYCLE_LIMIT  = N_OPS * 30 + RESET_CYCLES;

    logic              clk;
    logic              i_rst_n;
    logic              i_req_valid;
    logic              o_req_ready;
    logic              i_req_we;
    logic [ADDR_W-1:0] i_req_addr;
    size_e             i_req_size;
    logic              i_req_unsigned;
    word_t             i_req_wdata;
    logic              o_rsp_valid;
    word_t             o_rsp_rdata;
    logic              i_rsp_ready;

    logic [7:0]  ref_mem [MEM_BYTES];
    logic [31:0] lcg_state    = 32'd13;
    int          cycles       = 0;
    int          errors       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;

    unaligned_lsu uut (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_req_valid    (i_req_valid),
        .o_req_ready    (o_req_ready),
        .i_req_we       (i_req_we),
        .i_req_addr     (i_req_addr),
        .i_req_size     (i_req_size),
        .i_req_unsigned (i_req_unsigned),
        .i_req_wdata    (i_req_wdata),
        .o_rsp_valid    (o_rsp_valid),
        .o_rsp_rdata    (o_rsp_rdata),
        .i_rsp_ready    (i_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // upper half of the LCG state, low bits repeat too soon
    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic word_t fill_word(input logic [ADDR_W-1:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5AC3_3CA5;
    endfunction

    function automatic int byte_count(input size_e size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;   // 3 counts as word
        endcase
    endfunction

    // little-endian bytes, wrapping at the memory size
    task automatic ref_store(input logic [ADDR_W-1:0] addr, input size_e size,
                             input word_t data);
        for (int i = 0; i < byte_count(size); i++)
            ref_mem[(addr + i) % MEM_BYTES] = data[8*i +: 8];
    endtask

    function automatic word_t ref_load(input logic [ADDR_W-1:0] addr, input size_e size,
                                       input logic uns);
        word_t val;
        int    n;
        n   = byte_count(size);
        val = '0;
        for (int i = 0; i < n; i++)
            val[8*i +: 8] = ref_mem[(addr + i) % MEM_BYTES];
        if (!uns && n < 4 && val[8*n-1])
            val = val | (32'hFFFF_FFFF << (8 * n));   // sign fill
        return val;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic send_request(input logic we, input logic [ADDR_W-1:0] addr,
                                input size_e size, input logic uns, input word_t data,
                                input int hold);
        @(posedge clk);
        i_req_valid    <= 1'b1;
        i_req_we       <= we;
        i_req_addr     <= addr;
        i_req_size     <= size;
        i_req_unsigned <= uns;
        i_req_wdata    <= data;
        if (hold > 0)
            i_rsp_ready <= 1'b0;
        @(negedge clk);
        while (!o_req_ready)
            @(negedge clk);
        @(posedge clk);           // request taken on this edge
        i_req_valid <= 1'b0;
    endtask

    // hold > 0 keeps i_rsp_ready low for that many cycles of a valid response
    task automatic wait_response(input int hold, output word_t data);
        @(negedge clk);
        while (!o_rsp_valid)
            @(negedge clk);
        data = o_rsp_rdata;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_bit("o_rsp_valid", o_rsp_valid, 1'b1);
            check_bit("o_req_ready", o_req_ready, 1'b0);
            check_word("o_rsp_rdata", o_rsp_rdata, data);
        end
        if (hold > 0) begin
            @(posedge clk);
            i_rsp_ready <= 1'b1;
        end
        @(posedge clk);           // response taken here
        @(negedge clk);
        check_bit("o_rsp_valid", o_rsp_valid, 1'b0);   // exactly one response
    endtask

    task automatic do_store(input logic [ADDR_W-1:0] addr, input size_e size,
                            input word_t data, input int hold);
        word_t got;
        send_request(1'b1, addr, size, 1'b0, data, hold);
        wait_response(hold, got);
        check_word("o_rsp_rdata", got, '0);
        ref_store(addr, size, data);
    endtask

    task automatic do_load(input logic [ADDR_W-1:0] addr, input size_e size,
                           input logic uns, input int hold);
        word_t exp;
        word_t got;
        exp = ref_load(addr, size, uns);
        send_request(1'b0, addr, size, uns, '0, hold);
        wait_response(hold, got);
        check_word("o_rsp_rdata", got, exp);
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests_run++;
        if (errors != err_start) begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - err_start);
        end else begin
            $display("test %s passed", name);
        end
    endtask

    task automatic test_reset();
        int err0;
        err0 = errors;
        repeat (RESET_CYCLES / 2) @(negedge clk);
        check_bit("o_rsp_valid", o_rsp_valid, 1'b0);
        check_bit("o_req_ready", o_req_ready, 1'b1);
        repeat (RESET_CYCLES / 2) @(posedge clk);
        i_rst_n <= 1'b1;
        @(negedge clk);
        check_bit("o_rsp_valid", o_rsp_valid, 1'b0);
        check_bit("o_req_ready", o_req_ready, 1'b1);
        do_store(32'h0, SIZE_WORD, 32'hC0DE_1234, 0);
        do_load(32'h0, SIZE_WORD, 1'b0, 0);
        finish_test("reset", err0);
    endtask

    task automatic test_bytes();
        int err0;
        err0 = errors;
        for (int off = 0; off < 4; off++) begin
            // upper data bits are junk and must not land in memory
            do_store(off, SIZE_BYTE, 32'hABCD_EF00 | ((8'h37 * (off + 1)) & 8'hFF), 0);
            do_load(32'h0, SIZE_WORD, 1'b0, 0);
        end
        for (int off = 0; off < 4; off++) begin
            do_load(off, SIZE_BYTE, 1'b0, 0);
            do_load(off, SIZE_BYTE, 1'b1, 0);
        end
        finish_test("bytes", err0);
    endtask

    task automatic test_unaligned();
        int err0;
        err0 = errors;
        for (int w = 0; w < 3; w++)
            do_store(32'h20 + 4 * w, SIZE_WORD, fill_word(32'h20 + 4 * w), 0);
        for (int off = 1; off < 4; off++) begin
            do_store(32'h20 + off, SIZE_HALF, 32'h5555_0000 | (32'h96B0 + off * 32'h2211), 0);
            do_load(32'h20 + off, SIZE_HALF, 1'b0, 0);
            do_load(32'h20 + off, SIZE_HALF, 1'b1, 0);
            do_store(32'h24 + off, SIZE_WORD, 32'h1357_9BDF ^ (off * 32'h0102_0408), 0);
            do_load(32'h24 + off, SIZE_WORD, 1'b0, 0);
            do_load(32'h20, SIZE_WORD, 1'b0, 0);
            do_load(32'h24, SIZE_WORD, 1'b0, 0);
            do_load(32'h28, SIZE_WORD, 1'b0, 0);
        end
        finish_test("unaligned", err0);
    endtask

    task automatic test_random();
        int                err0;
        logic [15:0]       r;
        logic [ADDR_W-1:0] addr;
        word_t             data;
        err0 = errors;
        for (int w = 0; w < WIN_WORDS; w++)
            do_store(WIN_BASE + 4 * w, SIZE_WORD, fill_word(WIN_BASE + 4 * w), 0);
        for (int n = 0; n < N_RANDOM; n++) begin
            r    = lcg_next();
            addr = WIN_BASE + (lcg_next() % (4 * WIN_WORDS - 4));   // stays inside window
            data = {lcg_next(), lcg_next()};
            if (r[2])
                do_store(addr, size_e'(r[1:0]), data, 0);
            else
                do_load(addr, size_e'(r[1:0]), r[3], 0);
        end
        finish_test("random", err0);
    endtask

    task automatic test_backpressure();
        int err0;
        err0 = errors;
        do_store(WIN_BASE + 6, SIZE_WORD, 32'hFEED_F00D, 1 + lcg_next() % 12);
        do_load(WIN_BASE + 6, SIZE_WORD, 1'b0, 1 + lcg_next() % 12);
        do_load(WIN_BASE + 7, SIZE_HALF, 1'b0, 1 + lcg_next() % 12);
        do_load(WIN_BASE + 3, SIZE_BYTE, 1'b1, 1 + lcg_next() % 12);
        finish_test("backpressure", err0);
    endtask

    initial begin
        i_rst_n        = 1'b0;
        i_req_valid    = 1'b0;
        i_req_we       = 1'b0;
        i_req_addr     = '0;
        i_req_size     = SIZE_BYTE;
        i_req_unsigned = 1'b0;
        i_req_wdata    = '0;
        i_rsp_ready    = 1'b1;
        test_reset();
        test_bytes();
        test_unaligned();
        test_random();
        test_backpressure();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== unaligned_lsu.sv ====
/*
 * load/store unit top level with the word memory attached
 * one request outstanding, one response per request
 */
`timescale 1ns/1ns

module unaligned_lsu import lsu_pkg::*; (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_req_valid,
    output logic              o_req_ready,
    input  logic              i_req_we,
    input  logic [ADDR_W-1:0] i_req_addr,
    input  size_e             i_req_size,
    input  logic              i_req_unsigned,
    input  word_t             i_req_wdata,
    output logic              o_rsp_valid,
    output word_t             o_rsp_rdata,
    input  logic              i_rsp_ready
);

    logic       beat;
    logic [1:0] offset;
    size_e      size;
    logic       is_unsigned;
    word_t      wdata;
    logic [3:0] st_mask;
    word_t      st_data;
    word_t      ld_result;

    mem_if mem_bus ();

    access_sequencer u_seq (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_req_valid    (i_req_valid),
        .o_req_ready    (o_req_ready),
        .i_req_we       (i_req_we),
        .i_req_addr     (i_req_addr),
        .i_req_size     (i_req_size),
        .i_req_unsigned (i_req_unsigned),
        .i_req_wdata    (i_req_wdata),
        .o_rsp_valid    (o_rsp_valid),
        .o_rsp_rdata    (o_rsp_rdata),
        .i_rsp_ready    (i_rsp_ready),
        .o_beat         (beat),
        .o_offset       (offset),
        .o_size         (size),
        .o_unsigned     (is_unsigned),
        .o_wdata        (wdata),
        .i_st_mask      (st_mask),
        .i_st_data      (st_data),
        .i_ld_result    (ld_result),
        .mem            (mem_bus.seq)
    );

    store_splitter u_split (
        .i_beat   (beat),
        .i_offset (offset),
        .i_size   (size),
        .i_wdata  (wdata),
        .o_mask   (st_mask),
        .o_data   (st_data)
    );

    load_merger u_merge (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_rvalid   (mem_bus.rvalid),
        .i_beat     (beat),
        .i_rdata    (mem_bus.rdata),
        .i_offset   (offset),
        .i_size     (size),
        .i_unsigned (is_unsigned),
        .o_result   (ld_result)
    );

    word_mem u_mem (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .bus     (mem_bus.mem)
    );

endmodule

// ==== word_mem.sv ====
/*
 * byte-masked word memory standing in for the DRAM controller
 * busy for MEM_LAT cycles after every accepted beat
 * read data returns with rvalid in the last busy cycle
 * addresses wrap modulo the memory size, contents not reset
 */
`timescale 1ns/1ns

module word_mem import lsu_pkg::*; (
    input  logic clk,
    input  logic i_rst_n,
    mem_if.mem   bus
);

    word_t              mem_q [MEM_WORDS];
    word_t              rd_q;
    logic [BUSY_W-1:0]  busy_cnt;
    logic               rd_pend;     // read beat waiting for its rvalid
    logic               take;
    logic [MEM_AW-1:0]  idx;

    assign take = bus.req & bus.ready;
    assign idx  = bus.addr[2 +: MEM_AW];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_cnt <= '0;
            rd_pend  <= 1'b0;
        end else if (take) begin
            busy_cnt <= BUSY_W'(MEM_LAT);
            rd_pend  <= ~bus.we;
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
            if (busy_cnt == BUSY_W'(1))
                rd_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (bus.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus.mask[b])
                        mem_q[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end else begin
                rd_q <= mem_q[idx];   // held until the next read
            end
        end
    end

    assign bus.ready  = (busy_cnt == '0);
    assign bus.rvalid = rd_pend & (busy_cnt == BUSY_W'(1));
    assign bus.rdata  = rd_q;

endmodule

// ==== access_sequencer.sv ====
/*
 * request/response control for one access at a time
 * loads wait for each read return before the next beat
 * split stores are not atomic
 */
`timescale 1ns/1ns

module access_sequencer import lsu_pkg::*; (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_req_valid,
    output logic              o_req_ready,
    input  logic              i_req_we,
    input  logic [ADDR_W-1:0] i_req_addr,
    input  size_e             i_req_size,
    input  logic              i_req_unsigned,
    input  word_t             i_req_wdata,
    output logic              o_rsp_valid,
    output word_t             o_rsp_rdata,
    input  logic              i_rsp_ready,
    output logic              o_beat,
    output logic [1:0]        o_offset,
    output size_e             o_size,
    output logic              o_unsigned,
    output word_t             o_wdata,
    input  logic [3:0]        i_st_mask,
    input  word_t             i_st_data,
    input  word_t             i_ld_result,
    mem_if.seq                mem
);

    seq_state_e        state;
    logic              r_beat;
    logic              r_we;
    logic [1:0]        r_offset;
    size_e             r_size;
    logic              r_unsigned;
    word_t             r_wdata;
    logic [ADDR_W-1:0] r_maddr;     // word address of the current beat
    logic              req_take;
    logic              beat_take;
    logic              two_beats;
    logic              go_beat1;

    assign o_req_ready = (state == S_IDLE);
    assign req_take    = i_req_valid & o_req_ready;
    assign beat_take   = mem.req & mem.ready;
    assign two_beats   = needs_two_beats(r_offset, r_size);

    // second beat follows a store write or the first read return
    assign go_beat1 = two_beats & ~r_beat &
        (((state == S_BEAT0) & beat_take & r_we) | ((state == S_WAIT_RD) & mem.rvalid));

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= S_IDLE;
            r_beat <= 1'b0;
            r_we   <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (req_take) begin
                    state  <= S_BEAT0;
                    r_beat <= 1'b0;
                    r_we   <= i_req_we;
                end
                S_BEAT0, S_BEAT1: if (beat_take) begin
                    if (!r_we)
                        state <= S_WAIT_RD;
                    else if (go_beat1)
                        state <= S_BEAT1;
                    else
                        state <= S_RESP;   // response one cycle after last write
                end
                S_WAIT_RD: if (mem.rvalid) begin
                    state <= go_beat1 ? S_BEAT1 : S_RESP;
                end
                S_RESP: if (i_rsp_ready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
            if (go_beat1)
                r_beat <= 1'b1;
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (req_take) begin
            r_offset   <= i_req_addr[1:0];
            r_size     <= i_req_size;
            r_unsigned <= i_req_unsigned;
            r_wdata    <= i_req_wdata;
            r_maddr    <= {i_req_addr[ADDR_W-1:2], 2'b00};
        end else if (go_beat1) begin
            r_maddr <= r_maddr + ADDR_W'(4);
        end
    end

    assign o_beat     = r_beat;
    assign o_offset   = r_offset;
    assign o_size     = r_size;
    assign o_unsigned = r_unsigned;
    assign o_wdata    = r_wdata;

    assign mem.req   = (state == S_BEAT0) | (state == S_BEAT1);
    assign mem.we    = r_we;
    assign mem.addr  = r_maddr;
    assign mem.wdata = i_st_data;
    assign mem.mask  = i_st_mask;

    assign o_rsp_valid = (state == S_RESP);
    assign o_rsp_rdata = r_we ? '0 : i_ld_result;   // stores answer with zero

endmodule

// ==== load_merger.sv ====
/*
 * holds the read words of a load and extracts the result
 * o_result follows the captured words combinationally
 * second word ignored on single-beat accesses
 */
`timescale 1ns/1ns

module load_merger import lsu_pkg::*; (
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_rvalid,
    input  logic       i_beat,
    input  word_t      i_rdata,
    input  logic [1:0] i_offset,
    input  size_e      i_size,
    input  logic       i_unsigned,
    output word_t      o_result
);

    word_t               r_word0;
    word_t               r_word1;
    logic [2*DATA_W-1:0] shifted;
    logic                sign_bit;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_word0 <= '0;
            r_word1 <= '0;
        end else if (i_rvalid) begin
            if (i_beat)
                r_word1 <= i_rdata;
            else
                r_word0 <= i_rdata;
        end
    end

    // little-endian 8-byte view with the lowest wanted byte moved to lane 0
    assign shifted = {r_word1, r_word0} >> {i_offset, 3'b000};

    always_comb begin
        case (i_size)
            SIZE_BYTE: begin
                sign_bit = shifted[7] & ~i_unsigned;
                o_result = {{24{sign_bit}}, shifted[7:0]};
            end
            SIZE_HALF: begin
                sign_bit = shifted[15] & ~i_unsigned;
                o_result = {{16{sign_bit}}, shifted[15:0]};
            end
            default: begin
                sign_bit = 1'b0;                       // full word needs no extension
                o_result = shifted[DATA_W-1:0];
            end
        endcase
    end

endmodule

// ==== store_splitter.sv ====
/*
 * byte mask and lane-aligned data for one store beat
 * purely combinational
 * bytes outside the mask carry don't-care data
 */
`timescale 1ns/1ns

module store_splitter import lsu_pkg::*; (
    input  logic       i_beat,     // 0 = aligned word, 1 = next word
    input  logic [1:0] i_offset,
    input  size_e      i_size,
    input  word_t      i_wdata,
    output logic [3:0] o_mask,
    output word_t      o_data
);

    logic [3:0]        base_mask;
    logic [7:0]        wide_mask;
    logic [2*DATA_W-1:0] wide_data;

    always_comb begin
        case (i_size)
            SIZE_BYTE: base_mask = 4'b0001;
            SIZE_HALF: base_mask = 4'b0011;
            default:   base_mask = 4'b1111;
        endcase
    end

    // spread the access over two words, then pick the half for this beat
    assign wide_mask = {4'b0000, base_mask} << i_offset;
    assign wide_data = {{DATA_W{1'b0}}, i_wdata} << {i_offset, 3'b000};

    always_comb begin
        if (i_beat) begin
            o_mask = wide_mask[7:4];                   // overflow bytes land in low lanes
            o_data = wide_data[2*DATA_W-1:DATA_W];
        end else begin
            o_mask = wide_mask[3:0];
            o_data = wide_data[DATA_W-1:0];
        end
    end

endmodule

// ==== mem_if.sv ====
/*
 * word memory bus, one beat in flight at a time
 * addr is always word aligned, mask has one bit per byte lane
 */
`timescale 1ns/1ns

interface mem_if import lsu_pkg::*; ();

    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    word_t             wdata;
    logic [3:0]        mask;
    logic              ready;   // low while the memory is busy
    logic              rvalid;  // one-cycle pulse per read beat
    word_t             rdata;

    modport seq (
        output req, we, addr, wdata, mask,
        input  ready, rvalid, rdata
    );

    modport mem (
        input  req, we, addr, wdata, mask,
        output ready, rvalid, rdata
    );

endinterface

// ==== lsu_pkg.sv ====
/*
 * shared types and constants for the load/store unit
 * size value 3 behaves as a word access
 * MEM_LAT must be at least 1, MEM_WORDS a power of two
 */
package lsu_pkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int MEM_WORDS = 256;
    localparam int MEM_LAT   = 3;   // busy cycles after each accepted beat
    localparam int MEM_AW    = $clog2(MEM_WORDS);
    localparam int BUSY_W    = $clog2(MEM_LAT + 1);

    typedef logic [DATA_W-1:0] word_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_BEAT0,
        S_BEAT1,
        S_WAIT_RD,
        S_RESP
    } seq_state_e;

    // byte count of an access, 3 counts as word
    function automatic logic [2:0] size_bytes(size_e s);
        case (s)
            SIZE_BYTE: return 3'd1;
            SIZE_HALF: return 3'd2;
            default:   return 3'd4;
        endcase
    endfunction

    // access runs past byte 3 of the aligned word
    function automatic logic needs_two_beats(logic [1:0] off, size_e s);
        return ({1'b0, off} + size_bytes(s)) > 3'd4;
    endfunction

endpackage
